/* sim.f */
rtl/lcd_panel_pkg.sv
rtl/lcd_bus_pkg.sv
rtl/lcd_power_ctrl.sv
rtl/pixel_fifo.sv
rtl/pixel_pattern_gen.sv
rtl/lcd_frame_writer.sv
rtl/lcd_display_top.sv
tb/tb_lcd_display.sv

/* run.sh */
#!/bin/sh
# Build the LCD display testbench with Verilator, run it, and decide
# pass or fail from the simulation log.

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert \
    --top-module tb_lcd_display \
    -f sim.f \
    -o tb_sim \
    && ./obj_dir/tb_sim 2>&1 | tee sim.log

grep -q '\*\* PASS \*\*' sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

/* tb/tb_lcd_display.sv */
// ----------------------------------------
// Testbench for the MCU LCD display top
// Bring-up, command words, pixel streams
// checked against a reference model
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_lcd_display import lcd_panel_pkg::*, lcd_bus_pkg::*; ();

    localparam int FRAME_TIMEOUT   = 300000;  // About one 320x240 frame at 3 cycles per pixel
    localparam int PIXEL_TIMEOUT   = 20000;
    localparam int BRINGUP_TIMEOUT = PANEL_RST_CYCLES + PANEL_SETTLE_CYCLES + 16;

    logic        clk;
    logic        rst_n;
    logic [15:0] panel_id;
    lcd_bus_t    lcd_bus;
    logic        panel_rst;
    logic        backlight;

    // Scoreboard
    logic [16:0] strobe_q [$];   // {rs, data} per wr rising edge
    logic [16:0] captured;
    logic [15:0] cur_id;         // ID strapped at the last reset
    int          exp_idx;        // Word in frame with 0 for the command
    int          exp_frame;
    int          frames_done;
    int          cmd_count;
    int          pix_count;
    int          strobe_total;
    string       test_name;

    lcd_display_top i_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .panel_id  (panel_id),
        .lcd_bus   (lcd_bus),
        .panel_rst (panel_rst),
        .backlight (backlight)
    );

    always #10 clk = ~clk;  // 20 ns period

    // ----------------------------------------
    // Reference model
    // ----------------------------------------
    function automatic int panel_width(input logic [15:0] id);
        case (id)
            16'h9341: return 320;
            16'h5310: return 480;
            16'h5510: return 800;
            16'h1963: return 480;
            default:  return 0;   // Unknown panel
        endcase
    endfunction

    function automatic int panel_height(input logic [15:0] id);
        case (id)
            16'h9341: return 240;
            16'h5310: return 320;
            16'h5510: return 480;
            16'h1963: return 800;
            default:  return 0;
        endcase
    endfunction

    // Expected {rs, data} for word idx of a frame
    function automatic logic [16:0] expected_word(input logic [15:0] id, input int frame,
                                                  input int idx);
        int          pix;
        logic [31:0] x;
        logic [31:0] y;
        logic [31:0] f;
        if (idx == 0)
            return {1'b0, (id == 16'h5510) ? CMD_WRITE_GRAM_WIDE : CMD_WRITE_GRAM};
        pix = idx - 1;
        x   = pix % panel_width(id);   // Raster order
        y   = pix / panel_width(id);
        f   = frame;
        return {1'b1, x[4:0], y[5:0], f[4:0]};  // R from x, G from y, B from frame
    endfunction

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("** FAIL **");
        $fatal(1, "run aborted");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("error %s expected %h actual %h", name, expected, actual);
            $display("** FAIL **");
            $fatal(1, "value mismatch");
        end
    endtask

    // ----------------------------------------
    // Bus monitor and compare process
    // ----------------------------------------
    always @(posedge lcd_bus.wr) begin
        if (rst_n === 1'b1) begin            // Reset forcing wr high is no strobe
            strobe_q.push_back({lcd_bus.rs, lcd_bus.data});
            strobe_total++;
        end
    end

    always @(posedge clk) begin
        while (strobe_q.size() > 0) begin
            captured = strobe_q.pop_front();
            if (panel_width(cur_id) == 0)
                fail_run("write strobe seen for an unknown panel ID");
            check_value($sformatf("%s word %0d", test_name, exp_idx),
                        32'(expected_word(cur_id, exp_frame, exp_idx)), 32'(captured));
            if (exp_idx == 0)
                cmd_count++;
            else
                pix_count++;
            if (exp_idx == panel_width(cur_id) * panel_height(cur_id)) begin
                exp_idx = 0;                 // Next word is a new command
                exp_frame++;
                frames_done++;
            end else begin
                exp_idx++;
            end
        end
    end

    // ----------------------------------------
    // Stimulus and waits
    // ----------------------------------------
    task automatic reset_with_id(input logic [15:0] id);
        @(posedge clk);
        #2;
        rst_n        = 1'b0;
        panel_id     = id;
        cur_id       = id;
        strobe_q.delete();
        exp_idx      = 0;
        exp_frame    = 0;
        frames_done  = 0;
        cmd_count    = 0;
        pix_count    = 0;
        strobe_total = 0;
        repeat (10) @(posedge clk);
        #2;
        rst_n = 1'b1;
    endtask

    function automatic int progress(input string kind);
        if (kind == "commands")
            return cmd_count;
        else if (kind == "pixels")
            return pix_count;
        return frames_done;
    endfunction

    task automatic wait_count(input string kind, input int n, input int limit);
        int cycles;
        cycles = 0;
        while (progress(kind) < n) begin
            @(negedge clk);
            cycles++;
            if (cycles > limit)
                fail_run($sformatf("timed out waiting for %0d %s", n, kind));
        end
    endtask

    task automatic wait_panel_rst(input int limit);
        int cycles;
        cycles = 0;
        while (panel_rst !== 1'b1) begin
            @(negedge clk);
            cycles++;
            if (cycles > limit)
                fail_run("panel reset was not released in time");
        end
    endtask

    task automatic wait_init_done(input int limit);
        int cycles;
        cycles = 0;
        while (i_dut.init_done !== 1'b1) begin
            @(negedge clk);
            cycles++;
            if (cycles > limit)
                fail_run("init done never rose after reset");
        end
    endtask

    initial begin
        logic [15:0] rand_id;
        clk          = 1'b0;
        rst_n        = 1'b0;
        panel_id     = 16'h0000;
        cur_id       = 16'h0000;
        strobe_total = 0;
        test_name    = "reset_state";
        void'($urandom(32'h769d));

        // Reset state, then panel reset release
        reset_with_id(16'h9341);
        @(negedge clk);
        check_value("reset_state wr", 32'd1, 32'(lcd_bus.wr));
        check_value("reset_state rd", 32'd1, 32'(lcd_bus.rd));
        check_value("reset_state cs", 32'd0, 32'(lcd_bus.cs));
        check_value("reset_state backlight", 32'd1, 32'(backlight));
        check_value("reset_state panel_rst", 32'd0, 32'(panel_rst));
        wait_panel_rst(PANEL_RST_CYCLES + 4);

        // Command word and full frame 0 on the 320x240 panel
        test_name = "frame0_9341";
        wait_count("commands", 1, BRINGUP_TIMEOUT + PIXEL_TIMEOUT);
        wait_count("frames", 1, FRAME_TIMEOUT);

        // Second frame needs a command right after pixel 76800 and frame number 1
        test_name = "frame1_9341";
        wait_count("frames", 2, FRAME_TIMEOUT);

        // Unknown panel stays silent
        test_name = "unknown_id";
        reset_with_id(16'h1234);
        wait_init_done(BRINGUP_TIMEOUT);
        repeat (2000) @(negedge clk);
        check_value("unknown_id strobes", 32'd0, 32'(strobe_total));

        // Wide command format
        test_name = "command_5510";
        reset_with_id(16'h5510);
        wait_count("pixels", 2000, BRINGUP_TIMEOUT + PIXEL_TIMEOUT);

        // Random known panel
        case ($urandom % 4)
            0:       rand_id = 16'h9341;
            1:       rand_id = 16'h5310;
            2:       rand_id = 16'h5510;
            default: rand_id = 16'h1963;
        endcase
        test_name = $sformatf("random_%h", rand_id);
        reset_with_id(rand_id);
        wait_count("pixels", 2000, BRINGUP_TIMEOUT + PIXEL_TIMEOUT);

        $display("** PASS **");
        $finish;
    end

endmodule

`default_nettype wire

/* rtl/lcd_display_top.sv */
// ----------------------------------------
// MCU LCD display top
// Power-up, pattern source, pixel FIFO
// and 8080 frame writer
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module lcd_display_top import lcd_panel_pkg::*; import lcd_bus_pkg::*; (
    input  wire          clk,
    input  wire          rst_n,
    input  wire  [15:0]  panel_id,   // Strap pins
    output lcd_bus_t     lcd_bus,
    output logic         panel_rst,  // Active low
    output logic         backlight
);

    logic                  init_done;
    panel_geom_t           geom;
    logic [15:0]           frame_num;
    logic                  fifo_wr_en;
    pixel_t                fifo_wr_data;
    logic                  fifo_rd_en;
    pixel_t                fifo_rd_data;
    logic [FIFO_CNT_W-1:0] fifo_used;
    logic                  fifo_full;
    lcd_bus_t              writer_bus;

    assign backlight = 1'b1;  // Full brightness

    // Chip select tied active
    always_comb begin
        lcd_bus    = writer_bus;
        lcd_bus.cs = 1'b0;
    end

    lcd_power_ctrl u_power (
        .clk       (clk),
        .rst_n     (rst_n),
        .panel_rst (panel_rst),
        .init_done (init_done)
    );

    pixel_pattern_gen u_pattern (
        .clk       (clk),
        .rst_n     (rst_n),
        .geom      (geom),
        .frame_num (frame_num),
        .full      (fifo_full),
        .wr_en     (fifo_wr_en),
        .wr_data   (fifo_wr_data)
    );

    pixel_fifo u_fifo (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr_en   (fifo_wr_en),
        .wr_data (fifo_wr_data),
        .rd_en   (fifo_rd_en),
        .rd_data (fifo_rd_data),
        .used    (fifo_used),
        .full    (fifo_full)
    );

    lcd_frame_writer u_writer (
        .clk       (clk),
        .rst_n     (rst_n),
        .init_done (init_done),
        .panel_id  (panel_id),
        .rd_data   (fifo_rd_data),
        .used      (fifo_used),
        .rd_en     (fifo_rd_en),
        .bus       (writer_bus),
        .geom      (geom),
        .frame_num (frame_num)
    );

endmodule

`default_nettype wire

/* rtl/lcd_frame_writer.sv */
// ----------------------------------------
// 8080 frame writer
// Latches the panel ID, picks geometry and
// command word, then streams whole frames
// from the pixel FIFO onto the panel bus
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module lcd_frame_writer import lcd_panel_pkg::*; import lcd_bus_pkg::*; (
    input  wire                    clk,
    input  wire                    rst_n,
    input  wire                    init_done,
    input  wire  [15:0]            panel_id,
    input  pixel_t                 rd_data,
    input  wire  [FIFO_CNT_W-1:0]  used,
    output logic                   rd_en,
    output lcd_bus_t               bus,
    output panel_geom_t            geom,
    output logic [15:0]            frame_num
);

    logic          init_d0;
    logic          init_d1;
    logic          init_rise;
    logic [15:0]   id_r;
    logic [15:0]   cmd_word;
    writer_state_e state;
    logic [10:0]   h_cnt;       // Column of next fetch
    logic [10:0]   v_cnt;       // Row of next fetch
    logic          last_pix;    // Pixel in flight ends the frame
    logic          tail;
    logic          fetch_ok;

    // ----------------------------------------
    // Init done sync and panel recognition
    // ----------------------------------------
    assign init_rise = init_d0 & ~init_d1;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            init_d0 <= 1'b0;
            init_d1 <= 1'b0;
            id_r    <= '0;
            geom    <= '0;
        end else begin
            init_d0 <= init_done;
            init_d1 <= init_d0;
            if (init_rise) begin
                id_r <= panel_id;              // Straps are stable by now
                geom <= panel_geom(panel_id);
            end
        end
    end

    assign cmd_word = (id_r == PANEL_5510) ? CMD_WRITE_GRAM_WIDE : CMD_WRITE_GRAM;

    // Last few pixels of the frame, the generator has stopped so the FIFO
    // never climbs above the threshold again
    assign tail = (v_cnt == geom.height_m1) &&
                  (h_cnt + 11'(FETCH_THRESHOLD) > geom.width_m1);

    assign fetch_ok = (used > FIFO_CNT_W'(FETCH_THRESHOLD)) ||
                      (tail && (used != '0));

    // ----------------------------------------
    // Bus sequencer
    // ----------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bus       <= '{cs: 1'b0, wr: 1'b1, rd: 1'b1, rs: 1'b0, data: 16'h0000};
            rd_en     <= 1'b0;
            h_cnt     <= '0;
            v_cnt     <= '0;
            last_pix  <= 1'b0;
            frame_num <= '0;
            state     <= IDLE;
        end else begin
            bus.rd <= 1'b1;  // No readback
            case (state)
                IDLE: begin
                    bus.wr <= 1'b1;
                    rd_en  <= 1'b0;
                    if (init_d1 && geom.valid)
                        state <= CMD;       // Unknown panel parks here
                end
                CMD: begin                  // One-cycle command strobe
                    bus.wr   <= 1'b0;
                    bus.rs   <= 1'b0;
                    bus.data <= cmd_word;
                    h_cnt    <= '0;
                    v_cnt    <= '0;
                    state    <= WAIT_FIFO;
                end
                WAIT_FIFO: begin
                    bus.wr <= 1'b1;         // Rising wr latches data
                    if (fetch_ok) begin
                        rd_en    <= 1'b1;
                        last_pix <= (h_cnt == geom.width_m1) &&
                                    (v_cnt == geom.height_m1);
                        state    <= FETCH;
                        if (h_cnt == geom.width_m1) begin
                            h_cnt <= '0;
                            v_cnt <= (v_cnt == geom.height_m1) ? '0 : v_cnt + 1'b1;
                        end else begin
                            h_cnt <= h_cnt + 1'b1;
                        end
                    end
                end
                FETCH: begin
                    rd_en <= 1'b0;          // rd_data lands next cycle
                    state <= PIXEL;
                end
                PIXEL: begin
                    bus.wr   <= 1'b0;
                    bus.rs   <= 1'b1;
                    bus.data <= rd_data;
                    if (last_pix) begin
                        frame_num <= frame_num + 1'b1;
                        state     <= IDLE;
                    end else begin
                        state <= WAIT_FIFO;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Every write strobe is a single-cycle low pulse
    a_wr_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        !bus.wr |=> bus.wr);

endmodule

`default_nettype wire

/* rtl/pixel_pattern_gen.sv */
// ----------------------------------------
// Test pattern generator
// Writes one frame of RGB565 pixels in
// raster order, stalls on FIFO full
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module pixel_pattern_gen import lcd_panel_pkg::*; import lcd_bus_pkg::*; (
    input  wire          clk,
    input  wire          rst_n,
    input  panel_geom_t  geom,
    input  wire  [15:0]  frame_num,
    input  wire          full,
    output logic         wr_en,
    output pixel_t       wr_data
);

    logic [10:0] x_cnt;
    logic [10:0] y_cnt;
    logic        running;    // Frame still has pixels to write
    logic        valid_q;
    logic [15:0] frame_q;
    logic        start;

    // New panel known, or writer moved on to the next frame
    assign start = (geom.valid && !valid_q) || (frame_num != frame_q);

    assign wr_en   = running && !full;
    assign wr_data = pattern_pixel(x_cnt, y_cnt, frame_num);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            x_cnt   <= '0;
            y_cnt   <= '0;
            running <= 1'b0;
            valid_q <= 1'b0;
            frame_q <= '0;
        end else begin
            valid_q <= geom.valid;
            frame_q <= frame_num;
            if (start) begin
                x_cnt   <= '0;           // Raster restarts at (0,0)
                y_cnt   <= '0;
                running <= geom.valid;
            end else if (wr_en) begin
                if (x_cnt == geom.width_m1) begin
                    x_cnt <= '0;
                    if (y_cnt == geom.height_m1) begin
                        y_cnt   <= '0;
                        running <= 1'b0;  // Frame done, wait for next frame_num
                    end else begin
                        y_cnt <= y_cnt + 1'b1;
                    end
                end else begin
                    x_cnt <= x_cnt + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/pixel_fifo.sv */
// ----------------------------------------
// Synchronous pixel FIFO
// Dual-pointer RAM, registered read with
// one cycle latency, used-word count out
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module pixel_fifo import lcd_bus_pkg::*; (
    input  wire                    clk,
    input  wire                    rst_n,
    input  wire                    wr_en,
    input  pixel_t                 wr_data,
    input  wire                    rd_en,
    output pixel_t                 rd_data,
    output logic [FIFO_CNT_W-1:0]  used,
    output logic                   full
);

    pixel_t                 mem [FIFO_DEPTH];
    logic [FIFO_ADDR_W-1:0] wr_ptr;
    logic [FIFO_ADDR_W-1:0] rd_ptr;
    logic                   do_wr;
    logic                   do_rd;

    assign full  = (used == FIFO_CNT_W'(FIFO_DEPTH));
    assign do_wr = wr_en && !full;
    assign do_rd = rd_en && (used != '0);

    // ----------------------------------------
    // Storage and read port
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (do_wr)
            mem[wr_ptr] <= wr_data;
        if (do_rd)
            rd_data <= mem[rd_ptr];  // Valid the cycle after rd_en
    end

    // Pointers and fill level
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            used   <= '0;
        end else begin
            if (do_wr)
                wr_ptr <= wr_ptr + 1'b1;  // Wraps at depth
            if (do_rd)
                rd_ptr <= rd_ptr + 1'b1;
            case ({do_wr, do_rd})
                2'b10:   used <= used + 1'b1;
                2'b01:   used <= used - 1'b1;
                default: used <= used;     // Both or neither
            endcase
        end
    end

    // Producer must respect full, consumer must respect the count
    a_no_wr_full: assert property (@(posedge clk) disable iff (!rst_n)
        wr_en |-> !full);
    a_no_rd_empty: assert property (@(posedge clk) disable iff (!rst_n)
        rd_en |-> (used != '0));

endmodule

`default_nettype wire

/* rtl/lcd_power_ctrl.sv */
// ----------------------------------------
// Panel power-up controller
// Pulses panel reset low, waits for the
// panel to settle, then holds init done
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module lcd_power_ctrl import lcd_panel_pkg::*; (
    input  wire  clk,
    input  wire  rst_n,
    output logic panel_rst,  // Active low to the panel
    output logic init_done
);

    typedef enum logic [1:0] {
        RST_PULSE,
        SETTLE,
        READY
    } pwr_state_e;

    pwr_state_e           state;
    logic [PWR_CNT_W-1:0] cnt;

    // ----------------------------------------
    // Sequencer
    // ----------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= RST_PULSE;
            cnt   <= '0;
        end else begin
            case (state)
                RST_PULSE: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == PWR_CNT_W'(PANEL_RST_CYCLES - 1)) begin
                        cnt   <= '0;
                        state <= SETTLE;   // Release panel reset
                    end
                end
                SETTLE: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == PWR_CNT_W'(PANEL_SETTLE_CYCLES - 1)) begin
                        cnt   <= '0;
                        state <= READY;
                    end
                end
                READY:   state <= READY;   // Sticky until next reset
                default: state <= RST_PULSE;
            endcase
        end
    end

    assign panel_rst = (state != RST_PULSE);
    assign init_done = (state == READY);

    // Once up, the panel stays up until the next reset
    a_init_sticky: assert property (@(posedge clk) disable iff (!rst_n)
        init_done |=> init_done);

endmodule

`default_nettype wire

/* rtl/lcd_bus_pkg.sv */
// ----------------------------------------
// 8080 write bus and pixel path types
// Bus struct, pixel word, FIFO sizing,
// test pattern rule, writer states
// ----------------------------------------
`default_nettype none

package lcd_bus_pkg;

    // Panel side of the 8080 bus, strobes active low
    typedef struct packed {
        logic        cs;
        logic        wr;
        logic        rd;
        logic        rs;    // Low = command, high = data
        logic [15:0] data;
    } lcd_bus_t;

    typedef logic [15:0] pixel_t;  // RGB565

    // Pixel FIFO sizing
    localparam int FIFO_DEPTH      = 256;
    localparam int FIFO_ADDR_W     = 8;
    localparam int FIFO_CNT_W      = 9;  // Counts 0..FIFO_DEPTH
    localparam int FETCH_THRESHOLD = 8;  // Writer fetches above this fill

    // Test pattern: red from x, green from y, blue from frame
    function automatic pixel_t pattern_pixel(input logic [10:0] x,
                                             input logic [10:0] y,
                                             input logic [15:0] frame);
        return {x[4:0], y[5:0], frame[4:0]};
    endfunction

    // Frame writer sequencing
    typedef enum logic [2:0] {
        IDLE,       // Wait for init done and known panel
        CMD,        // Put out write-memory command
        WAIT_FIFO,  // Wait for enough pixels
        FETCH,      // FIFO read in flight
        PIXEL       // Put out one pixel
    } writer_state_e;

endpackage

`default_nettype wire

/* rtl/lcd_panel_pkg.sv */
// ----------------------------------------
// LCD panel definitions
// Known panel ID codes, geometry lookup,
// GRAM write commands, power-up timing
// ----------------------------------------
`default_nettype none

package lcd_panel_pkg;

    // Panel ID codes as read from the strap pins
    typedef enum logic [15:0] {
        PANEL_9341 = 16'h9341,  // 320x240
        PANEL_5310 = 16'h5310,  // 480x320
        PANEL_5510 = 16'h5510,  // 800x480, wide command format
        PANEL_1963 = 16'h1963   // 480 wide, 800 high
    } panel_id_e;

    // Last column and last row index
    typedef struct packed {
        logic [10:0] width_m1;
        logic [10:0] height_m1;
        logic        valid;     // Low for an unknown panel
    } panel_geom_t;

    // Write-memory command words
    localparam logic [15:0] CMD_WRITE_GRAM_WIDE = 16'h2C00;  // 0x5510 only
    localparam logic [15:0] CMD_WRITE_GRAM      = 16'h002C;

    // Power-up timing, in clk cycles
    localparam int PANEL_RST_CYCLES    = 64;
    localparam int PANEL_SETTLE_CYCLES = 64;
    localparam int PWR_CNT_MAX = (PANEL_RST_CYCLES > PANEL_SETTLE_CYCLES) ?
                                 PANEL_RST_CYCLES : PANEL_SETTLE_CYCLES;
    localparam int PWR_CNT_W   = $clog2(PWR_CNT_MAX);

    // ID to geometry, valid stays low for anything unknown
    function automatic panel_geom_t panel_geom(input logic [15:0] id);
        panel_geom_t g;
        g = '0;
        case (id)
            PANEL_9341: g = '{width_m1: 11'd319, height_m1: 11'd239, valid: 1'b1};
            PANEL_5310: g = '{width_m1: 11'd479, height_m1: 11'd319, valid: 1'b1};
            PANEL_5510: g = '{width_m1: 11'd799, height_m1: 11'd479, valid: 1'b1};
            PANEL_1963: g = '{width_m1: 11'd479, height_m1: 11'd799, valid: 1'b1};
            default:    g = '0;
        endcase
        return g;
    endfunction

endpackage

`default_nettype wire
